/* Bender.yml */
package:
  name: rs_serdes

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/rs_serdes_pkg.sv
      - rtl/rs_status_if.sv
      - rtl/rs_status_sync.sv
      - rtl/rs_serdes_seq.sv
      - rtl/rs_sigdet_mon.sv
      - rtl/rs_core_reset.sv
      - rtl/rs_serdes_top.sv
  - target: simulation
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_rs_serdes.sv

/* include/rs_serdes_settings.svh */
//////////////////////////////
// build-time sizes and counts for the reset sequencer
// wait loads assume pld_clk at 125 MHz or 250 MHz
// simulation loads apply only when sim_mode is high
//////////////////////////////
`ifndef RS_SERDES_SETTINGS_SVH
`define RS_SERDES_SETTINGS_SVH

// lane count and code widths
`define RS_LANES           8
`define RS_LTSSM_W         5
`define RS_SYNC_STAGES     3

// transceiver wait-state timer
`define RS_WS_W            20
`define RS_WS_SIM          32
`define RS_WS_1MS_125      125000
`define RS_WS_1MS_250      250000

// tx pll stability and rx lock hysteresis
`define RS_PLL_STABLE_CNT  127
`define RS_FREQ_HYST       7

// signal-detect stability
`define RS_SD_W            20
`define RS_SD_IDLE_MAX     750000
`define RS_SD_IDLE_SIM     32
`define RS_SD_BACKOFF      10

// core reset counter
`define RS_RST_CNT_W       11
`define RS_RST_CNT_MAX     1024
`define RS_RST_CNT_RELOAD  1008
`define RS_RST_CNT_SIM     32

`endif

/* rtl/rs_core_reset.sv */
//////////////////////////////
// exit inputs are active low
// crst and srst release together one cycle after the count
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rs_serdes_settings.svh"

module rs_core_reset (
   input  logic      pld_clk,
   input  logic      arst,
   input  logic      sim_mode,
   input  logic      dlup_exit,
   input  logic      hotrst_exit,
   input  logic      l2_exit,
   rs_status_if.core st,
   output logic      crst,
   output logic      srst
);

   localparam rs_serdes_pkg::rst_count_t cnt_max =
      rs_serdes_pkg::rst_count_t'(`RS_RST_CNT_MAX);

   rs_serdes_pkg::rst_count_t rst_cnt;
   rs_serdes_pkg::rst_count_t release_cnt;
   logic                      dlup_exit_q;
   logic                      hotrst_exit_q;
   logic                      l2_exit_q;
   logic                      exits_q;
   logic                      rst0;

   assign release_cnt = sim_mode ? rs_serdes_pkg::rst_count_t'(`RS_RST_CNT_SIM) : cnt_max;

   // one exit pulse from any link exit or a disabled / hot reset ltssm
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         dlup_exit_q   <= 1'b1;
         hotrst_exit_q <= 1'b1;
         l2_exit_q     <= 1'b1;
         exits_q       <= 1'b0;
      end else begin
         dlup_exit_q   <= dlup_exit;
         hotrst_exit_q <= hotrst_exit;
         l2_exit_q     <= l2_exit;
         exits_q       <= !dlup_exit_q || !hotrst_exit_q || !l2_exit_q ||
                          (st.ltssm_qq == rs_serdes_pkg::ltssm_disabled) ||
                          (st.ltssm_qq == rs_serdes_pkg::ltssm_hot_reset);
      end
   end

   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         rst_cnt <= '0;
         rst0    <= 1'b1;
         crst    <= 1'b1;
         srst    <= 1'b1;
      end else begin
         if (exits_q) begin
            rst_cnt <= rs_serdes_pkg::rst_count_t'(`RS_RST_CNT_RELOAD);
         end else if (rst_cnt != cnt_max) begin
            rst_cnt <= rst_cnt + 1'b1;
         end
         if (exits_q) begin
            rst0 <= 1'b1;
         end else if (rst_cnt >= release_cnt) begin
            rst0 <= 1'b0;
         end
         // output pipeline stage
         crst <= rst0;
         srst <= rst0;
      end
   end

endmodule

`default_nettype wire

/* rtl/rs_serdes_pkg.sv */
//////////////////////////////
// shared types for the reset sequencer
// ltssm codes follow the hard ip encoding
//////////////////////////////
`default_nettype none

`include "rs_serdes_settings.svh"

package rs_serdes_pkg;

   typedef logic [`RS_LANES-1:0]     lane_mask_t;
   typedef logic [`RS_LTSSM_W-1:0]   ltssm_t;
   typedef logic [`RS_WS_W-1:0]      ws_count_t;
   typedef logic [`RS_SD_W-1:0]      sd_count_t;
   typedef logic [`RS_RST_CNT_W-1:0] rst_count_t;

   typedef enum logic [1:0] {wait_tx_pll, stable_tx_pll, wait_rx, idle} serdes_state_e;
   typedef enum logic [1:0] {sd_idle, sd_reset, sd_done} sd_state_e;

   localparam ltssm_t ltssm_detect_quiet  = ltssm_t'(0);
   localparam ltssm_t ltssm_detect_active = ltssm_t'(1);
   localparam ltssm_t ltssm_polling       = ltssm_t'(2);
   localparam ltssm_t ltssm_disabled      = ltssm_t'(16);
   localparam ltssm_t ltssm_hot_reset     = ltssm_t'(20);

endpackage

`default_nettype wire

/* rtl/rs_serdes_seq.sv */
//////////////////////////////
// orders tx digital, rx analog and rx digital reset release
// clk_125 selects the 1 ms load, ignored when sim_mode is high
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rs_serdes_settings.svh"

module rs_serdes_seq (
   input  logic      pld_clk,
   input  logic      arst,
   input  logic      sim_mode,
   input  logic      clk_125,
   rs_status_if.seq  st,
   output logic      txdigitalreset,
   output logic      rxanalogreset,
   output logic      rx_digital_hold
);

   localparam int pll_cnt_w = $clog2(`RS_PLL_STABLE_CNT + 1);
   localparam rs_serdes_pkg::ws_count_t ws_short = rs_serdes_pkg::ws_count_t'(`RS_WS_SIM);

   rs_serdes_pkg::serdes_state_e state;
   rs_serdes_pkg::ws_count_t     ws_tmr;
   rs_serdes_pkg::ws_count_t     ws_full;
   logic                         ws_done;
   logic                         ld_full;
   logic                         ld_short;
   logic [pll_cnt_w-1:0]         pll_cnt;
   logic                         pll_stable;

   assign ws_full = sim_mode ? ws_short :
                    clk_125  ? rs_serdes_pkg::ws_count_t'(`RS_WS_1MS_125) :
                               rs_serdes_pkg::ws_count_t'(`RS_WS_1MS_250);

   // tx pll must stay locked for a full count
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         pll_cnt    <= '0;
         pll_stable <= 1'b0;
      end else begin
         if (!st.pll_locked_sync) begin
            pll_cnt <= '0;
         end else if (pll_cnt != pll_cnt_w'(`RS_PLL_STABLE_CNT)) begin
            pll_cnt <= pll_cnt + 1'b1;
         end
         pll_stable <= (pll_cnt == pll_cnt_w'(`RS_PLL_STABLE_CNT));
      end
   end

   //////////////////////////////
   // wait-state timer
   //////////////////////////////
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         ws_tmr  <= '1;
         ws_done <= 1'b0;
      end else begin
         if (ld_full) begin
            ws_tmr <= ws_full;
         end else if (ld_short) begin
            ws_tmr <= ws_short;
         end else if (ws_tmr != '0) begin
            ws_tmr <= ws_tmr - 1'b1;
         end
         ws_done <= !(ld_full || ld_short) && (ws_tmr == '0);
      end
   end

   //////////////////////////////
   // sequencer FSM
   //////////////////////////////
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         state           <= rs_serdes_pkg::wait_tx_pll;
         ld_full         <= 1'b1;
         ld_short        <= 1'b0;
         txdigitalreset  <= 1'b1;
         rxanalogreset   <= 1'b1;
         rx_digital_hold <= 1'b1;
      end else begin
         // loads are single-cycle strobes
         ld_full  <= 1'b0;
         ld_short <= 1'b0;
         case (state)
            rs_serdes_pkg::wait_tx_pll: begin
               rx_digital_hold <= 1'b1;
               if (st.pll_locked_sync && pll_stable && ws_done && !ld_full) begin
                  txdigitalreset <= st.tx_cal_busy_sync;
                  rxanalogreset  <= st.rx_cal_busy_sync;
                  if (!st.tx_cal_busy_sync && !st.rx_cal_busy_sync) begin
                     state <= rs_serdes_pkg::stable_tx_pll;
                  end
               end else begin
                  txdigitalreset <= 1'b1;
                  rxanalogreset  <= 1'b1;
               end
            end
            rs_serdes_pkg::stable_tx_pll: begin
               txdigitalreset  <= st.tx_cal_busy_sync;
               rxanalogreset   <= st.rx_cal_busy_sync;
               rx_digital_hold <= 1'b1;
               if (st.rx_locked_ok && !st.rx_cal_busy_sync) begin
                  state    <= rs_serdes_pkg::wait_rx;
                  ld_short <= 1'b1;
               end
            end
            rs_serdes_pkg::wait_rx: begin
               txdigitalreset <= st.tx_cal_busy_sync;
               rxanalogreset  <= st.rx_cal_busy_sync;
               if (!st.rx_locked_ok || st.rx_cal_busy_sync) begin
                  state <= rs_serdes_pkg::stable_tx_pll;
               end else if (!ld_short && ws_done) begin
                  state           <= rs_serdes_pkg::idle;
                  rx_digital_hold <= 1'b0;
               end
            end
            rs_serdes_pkg::idle: begin
               txdigitalreset <= st.tx_cal_busy_sync;
               rxanalogreset  <= st.rx_cal_busy_sync;
               if (!st.rx_locked_ok) begin
                  // lost lock restarts the whole sequence
                  state           <= rs_serdes_pkg::wait_tx_pll;
                  ld_full         <= 1'b1;
                  rx_digital_hold <= 1'b1;
               end else if (st.fifo_err_sync || st.rx_cal_busy_sync) begin
                  state           <= rs_serdes_pkg::stable_tx_pll;
                  rx_digital_hold <= 1'b1;
               end
            end
            default: begin
               state <= rs_serdes_pkg::wait_tx_pll;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/rs_serdes_top.sv */
//////////////////////////////
// arst is asynchronous and active high
// sim_mode shortens every wait for simulation
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rs_serdes_top (
   input  logic                      pld_clk,
   input  logic                      arst,
   input  logic                      sim_mode,
   input  logic                      clk_125,
   input  rs_serdes_pkg::ltssm_t     ltssm,
   input  logic                      dlup_exit,
   input  logic                      hotrst_exit,
   input  logic                      l2_exit,
   input  logic                      pll_locked,
   input  logic                      tx_cal_busy,
   input  logic                      rx_cal_busy,
   input  logic                      fifo_err,
   input  rs_serdes_pkg::lane_mask_t rx_pll_locked,
   input  rs_serdes_pkg::lane_mask_t rx_freqlocked,
   input  rs_serdes_pkg::lane_mask_t rx_signaldetect,
   output logic                      crst,
   output logic                      srst,
   output logic                      txdigitalreset,
   output logic                      rxanalogreset,
   output logic                      rxdigitalreset
);

   logic rx_digital_hold;
   logic rst_rxpcs;

   rs_status_if status_if_inst ();

   rs_status_sync status_sync_inst (
      .pld_clk         (pld_clk),
      .arst            (arst),
      .pll_locked      (pll_locked),
      .tx_cal_busy     (tx_cal_busy),
      .rx_cal_busy     (rx_cal_busy),
      .fifo_err        (fifo_err),
      .rx_pll_locked   (rx_pll_locked),
      .rx_freqlocked   (rx_freqlocked),
      .rx_signaldetect (rx_signaldetect),
      .ltssm           (ltssm),
      .st              (status_if_inst.src)
   );

   rs_serdes_seq serdes_seq_inst (
      .pld_clk         (pld_clk),
      .arst            (arst),
      .sim_mode        (sim_mode),
      .clk_125         (clk_125),
      .st              (status_if_inst.seq),
      .txdigitalreset  (txdigitalreset),
      .rxanalogreset   (rxanalogreset),
      .rx_digital_hold (rx_digital_hold)
   );

   rs_sigdet_mon sigdet_mon_inst (
      .pld_clk   (pld_clk),
      .arst      (arst),
      .sim_mode  (sim_mode),
      .st        (status_if_inst.sigdet),
      .rst_rxpcs (rst_rxpcs)
   );

   rs_core_reset core_reset_inst (
      .pld_clk     (pld_clk),
      .arst        (arst),
      .sim_mode    (sim_mode),
      .dlup_exit   (dlup_exit),
      .hotrst_exit (hotrst_exit),
      .l2_exit     (l2_exit),
      .st          (status_if_inst.core),
      .crst        (crst),
      .srst        (srst)
   );

   // rx pcs held by either the sequencer or the signal-detect monitor
   assign rxdigitalreset = rx_digital_hold | rst_rxpcs;

endmodule

`default_nettype wire

/* rtl/rs_sigdet_mon.sv */
//////////////////////////////
// holds the rx pcs in reset from polling entry until
// all lanes' signal detect is stable and not all zero
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rs_serdes_settings.svh"

module rs_sigdet_mon (
   input  logic         pld_clk,
   input  logic         arst,
   input  logic         sim_mode,
   rs_status_if.sigdet  st,
   output logic         rst_rxpcs
);

   localparam rs_serdes_pkg::sd_count_t backoff =
      rs_serdes_pkg::sd_count_t'(`RS_SD_BACKOFF);

   rs_serdes_pkg::sd_state_e  sd_state;
   rs_serdes_pkg::sd_count_t  sd_cnt;
   rs_serdes_pkg::sd_count_t  sd_limit;
   rs_serdes_pkg::lane_mask_t sd_strb0;
   rs_serdes_pkg::lane_mask_t sd_strb1;
   logic                      stable_sd;
   logic                      in_detect;
   logic                      in_polling;

   assign sd_limit = sim_mode ? rs_serdes_pkg::sd_count_t'(`RS_SD_IDLE_SIM) :
                                rs_serdes_pkg::sd_count_t'(`RS_SD_IDLE_MAX);

   assign in_detect  = (st.ltssm_q == rs_serdes_pkg::ltssm_detect_quiet) ||
                       (st.ltssm_q == rs_serdes_pkg::ltssm_detect_active);
   assign in_polling = (st.ltssm_q == rs_serdes_pkg::ltssm_polling);

   // two samples agree and at least one lane sees signal
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         sd_strb0 <= '0;
         sd_strb1 <= '0;
      end else begin
         sd_strb0 <= st.sd_sync;
         sd_strb1 <= sd_strb0;
      end
   end

   assign stable_sd = (sd_strb1 == sd_strb0) && (sd_strb1 != '0);

   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         sd_state <= rs_serdes_pkg::sd_idle;
         sd_cnt   <= '0;
      end else begin
         case (sd_state)
            rs_serdes_pkg::sd_idle: begin
               if (in_polling) begin
                  sd_cnt   <= (sd_cnt > backoff) ? sd_cnt - backoff : '0;
                  sd_state <= rs_serdes_pkg::sd_reset;
               end else if (!stable_sd) begin
                  sd_cnt <= '0;
               end else if (sd_cnt < sd_limit) begin
                  sd_cnt <= sd_cnt + 1'b1;
               end
            end
            rs_serdes_pkg::sd_reset: begin
               if (!stable_sd) begin
                  sd_cnt <= '0;
                  if (in_detect) begin
                     sd_state <= rs_serdes_pkg::sd_idle;
                  end
               end else if (sd_cnt >= sd_limit) begin
                  sd_cnt   <= sd_limit;
                  sd_state <= rs_serdes_pkg::sd_done;
               end else begin
                  sd_cnt <= sd_cnt + 1'b1;
               end
            end
            rs_serdes_pkg::sd_done: begin
               if (!stable_sd) begin
                  sd_cnt <= '0;
                  if (in_detect) begin
                     sd_state <= rs_serdes_pkg::sd_idle;
                  end
               end
            end
            default: begin
               sd_state <= rs_serdes_pkg::sd_idle;
               sd_cnt   <= '0;
            end
         endcase
      end
   end

   assign rst_rxpcs = (sd_state == rs_serdes_pkg::sd_reset);

endmodule

`default_nettype wire

/* rtl/rs_status_if.sv */
//////////////////////////////
// status already in the pld_clk domain
// only the input side drives it
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rs_serdes_settings.svh"

interface rs_status_if;
   logic                     pll_locked_sync;
   logic                     rx_locked_ok;
   logic                     tx_cal_busy_sync;
   logic                     rx_cal_busy_sync;
   logic                     fifo_err_sync;
   logic [`RS_LANES-1:0]     sd_sync;
   logic [`RS_LTSSM_W-1:0]   ltssm_q;
   logic [`RS_LTSSM_W-1:0]   ltssm_qq;

   modport src (
      output pll_locked_sync, rx_locked_ok, tx_cal_busy_sync, rx_cal_busy_sync,
      output fifo_err_sync, sd_sync, ltssm_q, ltssm_qq
   );
   modport seq (
      input pll_locked_sync, rx_locked_ok, tx_cal_busy_sync, rx_cal_busy_sync, fifo_err_sync
   );
   modport sigdet (input sd_sync, ltssm_q);
   modport core (input ltssm_qq);
endinterface

`default_nettype wire

/* rtl/rs_status_sync.sv */
//////////////////////////////
// every status input is taken as asynchronous to pld_clk
// per-lane rx pll lock is sticky until arst
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "rs_serdes_settings.svh"

module rs_status_sync (
   input  logic                      pld_clk,
   input  logic                      arst,
   input  logic                      pll_locked,
   input  logic                      tx_cal_busy,
   input  logic                      rx_cal_busy,
   input  logic                      fifo_err,
   input  rs_serdes_pkg::lane_mask_t rx_pll_locked,
   input  rs_serdes_pkg::lane_mask_t rx_freqlocked,
   input  rs_serdes_pkg::lane_mask_t rx_signaldetect,
   input  rs_serdes_pkg::ltssm_t     ltssm,
   rs_status_if.src                  st
);

   localparam int sync_w = 5 + 2 * `RS_LANES;
   localparam int hyst_w = $clog2(`RS_FREQ_HYST + 1);
   // cal busy bits sit on top and come out of reset busy
   localparam logic [sync_w-1:0] sync_rst = {2'b11, {(sync_w - 2){1'b0}}};

   logic [`RS_SYNC_STAGES-1:0][sync_w-1:0] sync_q;
   logic [sync_w-1:0]                      sync_in;
   rs_serdes_pkg::lane_mask_t              rx_pll_locked_sync;
   logic                                   rx_pll_seen;
   logic                                   lock_term;
   logic                                   lock_term_sync;
   logic [hyst_w-1:0]                      hyst_cnt;

   // lane lock counts once every lane has shown pll lock or freq lock
   assign lock_term = rx_pll_seen | (&rx_freqlocked);

   assign sync_in = {tx_cal_busy, rx_cal_busy, pll_locked, fifo_err, lock_term,
                     rx_signaldetect, rx_pll_locked};

   //////////////////////////////
   // synchronizer chain
   //////////////////////////////
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         sync_q <= {`RS_SYNC_STAGES{sync_rst}};
      end else begin
         sync_q <= {sync_q[`RS_SYNC_STAGES-2:0], sync_in};
      end
   end

   assign {st.tx_cal_busy_sync, st.rx_cal_busy_sync, st.pll_locked_sync, st.fifo_err_sync,
           lock_term_sync, st.sd_sync, rx_pll_locked_sync} = sync_q[`RS_SYNC_STAGES-1];

   // sticky lane lock and hysteresis on loss of lock
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         rx_pll_seen     <= 1'b0;
         hyst_cnt        <= '0;
         st.rx_locked_ok <= 1'b0;
      end else begin
         if (&rx_pll_locked_sync) begin
            rx_pll_seen <= 1'b1;
         end
         if (lock_term_sync) begin
            hyst_cnt        <= hyst_w'(`RS_FREQ_HYST);
            st.rx_locked_ok <= 1'b1;
         end else if (hyst_cnt != '0) begin
            hyst_cnt <= hyst_cnt - 1'b1;
         end else begin
            st.rx_locked_ok <= 1'b0;
         end
      end
   end

   // ltssm history
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         st.ltssm_q  <= rs_serdes_pkg::ltssm_detect_quiet;
         st.ltssm_qq <= rs_serdes_pkg::ltssm_detect_quiet;
      end else begin
         st.ltssm_q  <= ltssm;
         st.ltssm_qq <= st.ltssm_q;
      end
   end

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
//////////////////////////////
// pld_clk with a 40 ns period
// arst released on a falling edge after 10 cycles
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic pld_clk,
   output logic arst
);

   localparam int half_period = 20;
   localparam int rst_cycles  = 10;

   initial begin
      pld_clk = 1'b0;
      forever #half_period pld_clk = ~pld_clk;
   end

   initial begin
      arst = 1'b1;
      repeat (rst_cycles) @(posedge pld_clk);
      @(negedge pld_clk);
      arst = 1'b0;
   end

endmodule

`default_nettype wire

/* tb/tb_rs_serdes.sv */
//////////////////////////////
// runs the DUT with sim_mode and clk_125 held high
// a row passes once all five resets reach its levels and then hold them
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_rs_serdes;

   localparam int n_rows        = 21;
   localparam int row_timeout   = 2000;
   localparam int reset_timeout = 100;
   localparam int hold_cycles   = 8;

   // stimulus and the levels of crst, srst, txd, rxa, rxd it must settle to
   typedef struct packed {
      logic                      pll_locked;
      logic                      tx_cal_busy;
      logic                      rx_cal_busy;
      logic                      fifo_err;
      logic                      dlup_exit;
      logic                      hotrst_exit;
      logic                      l2_exit;
      rs_serdes_pkg::lane_mask_t rx_pll_locked;
      rs_serdes_pkg::lane_mask_t sigdet;
      logic                      rand_ltssm;
      rs_serdes_pkg::ltssm_t     ltssm;
      logic [4:0]                expect_rst;
   } row_t;

   logic                      pld_clk;
   logic                      arst;
   logic                      sim_mode;
   logic                      clk_125;
   rs_serdes_pkg::ltssm_t     ltssm;
   logic                      dlup_exit;
   logic                      hotrst_exit;
   logic                      l2_exit;
   logic                      pll_locked;
   logic                      tx_cal_busy;
   logic                      rx_cal_busy;
   logic                      fifo_err;
   rs_serdes_pkg::lane_mask_t rx_pll_locked;
   rs_serdes_pkg::lane_mask_t rx_freqlocked;
   rs_serdes_pkg::lane_mask_t rx_signaldetect;
   logic                      crst;
   logic                      srst;
   logic                      txdigitalreset;
   logic                      rxanalogreset;
   logic                      rxdigitalreset;
   logic [4:0]                rst_levels;
   row_t                      rows [n_rows];
   logic [31:0]               lfsr_state;

   assign rst_levels = {crst, srst, txdigitalreset, rxanalogreset, rxdigitalreset};

   tb_clk_gen clk_gen_inst (
      .pld_clk (pld_clk),
      .arst    (arst)
   );

   rs_serdes_top rs_serdes_top_inst (
      .pld_clk         (pld_clk),
      .arst            (arst),
      .sim_mode        (sim_mode),
      .clk_125         (clk_125),
      .ltssm           (ltssm),
      .dlup_exit       (dlup_exit),
      .hotrst_exit     (hotrst_exit),
      .l2_exit         (l2_exit),
      .pll_locked      (pll_locked),
      .tx_cal_busy     (tx_cal_busy),
      .rx_cal_busy     (rx_cal_busy),
      .fifo_err        (fifo_err),
      .rx_pll_locked   (rx_pll_locked),
      .rx_freqlocked   (rx_freqlocked),
      .rx_signaldetect (rx_signaldetect),
      .crst            (crst),
      .srst            (srst),
      .txdigitalreset  (txdigitalreset),
      .rxanalogreset   (rxanalogreset),
      .rxdigitalreset  (rxdigitalreset)
   );

   //////////////////////////////
   // stimulus table
   //////////////////////////////
   task automatic load_table();
      // ctl bits in order pll txcal rxcal fifo dlup hotrst l2
      // exit bits are active low
      //            ctl         rx_pll sigdet rnd ltssm  crst srst txd rxa rxd
      rows[0]  = {7'b0000111, 8'h00, 8'hff, 1'b1, 5'd0,  5'b00111};
      rows[1]  = {7'b1000111, 8'hff, 8'hff, 1'b1, 5'd0,  5'b00000};
      rows[2]  = {7'b1100111, 8'hff, 8'hff, 1'b1, 5'd0,  5'b00100};
      rows[3]  = {7'b1110111, 8'hff, 8'hff, 1'b1, 5'd0,  5'b00111};
      rows[4]  = {7'b1010111, 8'hff, 8'hff, 1'b1, 5'd0,  5'b00011};
      rows[5]  = {7'b1000111, 8'hff, 8'hff, 1'b1, 5'd0,  5'b00000};
      rows[6]  = {7'b1001111, 8'hff, 8'hff, 1'b1, 5'd0,  5'b00001};
      rows[7]  = {7'b1000111, 8'hff, 8'hff, 1'b1, 5'd0,  5'b00000};
      rows[8]  = {7'b1000011, 8'hff, 8'hff, 1'b1, 5'd0,  5'b11000};
      rows[9]  = {7'b1000111, 8'hff, 8'hff, 1'b1, 5'd0,  5'b00000};
      rows[10] = {7'b1000101, 8'hff, 8'hff, 1'b1, 5'd0,  5'b11000};
      rows[11] = {7'b1000111, 8'hff, 8'hff, 1'b1, 5'd0,  5'b00000};
      rows[12] = {7'b1000110, 8'hff, 8'hff, 1'b1, 5'd0,  5'b11000};
      rows[13] = {7'b1000111, 8'hff, 8'hff, 1'b1, 5'd0,  5'b00000};
      rows[14] = {7'b1000111, 8'hff, 8'hff, 1'b0, 5'd16, 5'b11000};
      rows[15] = {7'b1000111, 8'hff, 8'hff, 1'b1, 5'd0,  5'b00000};
      rows[16] = {7'b1000111, 8'hff, 8'hff, 1'b0, 5'd20, 5'b11000};
      rows[17] = {7'b1000111, 8'hff, 8'hff, 1'b1, 5'd0,  5'b00000};
      // back to detect with no signal, then polling without and with signal
      rows[18] = {7'b1000111, 8'hff, 8'h00, 1'b0, 5'd0,  5'b00000};
      rows[19] = {7'b1000111, 8'hff, 8'h00, 1'b0, 5'd2,  5'b00001};
      rows[20] = {7'b1000111, 8'hff, 8'hff, 1'b0, 5'd2,  5'b00000};
   endtask

   // galois lfsr with polynomial x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h8020_0003;
      end
      return n;
   endfunction

   task automatic take_bit(output logic b);
      b          = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
   endtask

   task automatic draw_lane_mask(output rs_serdes_pkg::lane_mask_t m);
      logic b;
      for (int i = 0; i < $bits(m); i++) begin
         take_bit(b);
         m[i] = b;
      end
   endtask

   // polling, disabled and hot reset move up by 8 to a neutral code
   task automatic draw_ltssm(output rs_serdes_pkg::ltssm_t c);
      logic b;
      for (int i = 0; i < $bits(c); i++) begin
         take_bit(b);
         c[i] = b;
      end
      if (c == rs_serdes_pkg::ltssm_polling || c == rs_serdes_pkg::ltssm_disabled ||
          c == rs_serdes_pkg::ltssm_hot_reset) begin
         c[3] = 1'b1;
      end
   endtask

   //////////////////////////////
   // checks
   //////////////////////////////
   task automatic end_with_failure();
      $display("Done: errors found");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_reset_level(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         end_with_failure();
      end
   endtask

   task automatic check_lane_mask(input string what, input rs_serdes_pkg::lane_mask_t got,
                                  input rs_serdes_pkg::lane_mask_t exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         end_with_failure();
      end
   endtask

   task automatic check_ltssm_code(input string what, input rs_serdes_pkg::ltssm_t got,
                                   input rs_serdes_pkg::ltssm_t exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
         end_with_failure();
      end
   endtask

   task automatic check_all_resets(input logic [4:0] exp);
      check_reset_level("crst", crst, exp[4]);
      check_reset_level("srst", srst, exp[3]);
      check_reset_level("txdigitalreset", txdigitalreset, exp[2]);
      check_reset_level("rxanalogreset", rxanalogreset, exp[1]);
      check_reset_level("rxdigitalreset", rxdigitalreset, exp[0]);
   endtask

   //////////////////////////////
   // row application
   //////////////////////////////
   task automatic apply_row(input int r);
      rs_serdes_pkg::lane_mask_t freq;
      rs_serdes_pkg::ltssm_t     code;
      draw_lane_mask(freq);
      if (rows[r].rand_ltssm) begin
         draw_ltssm(code);
      end else begin
         code = rows[r].ltssm;
      end
      pll_locked      = rows[r].pll_locked;
      tx_cal_busy     = rows[r].tx_cal_busy;
      rx_cal_busy     = rows[r].rx_cal_busy;
      fifo_err        = rows[r].fifo_err;
      dlup_exit       = rows[r].dlup_exit;
      hotrst_exit     = rows[r].hotrst_exit;
      l2_exit         = rows[r].l2_exit;
      rx_pll_locked   = rows[r].rx_pll_locked;
      rx_signaldetect = rows[r].sigdet;
      rx_freqlocked   = freq;
      ltssm           = code;
   endtask

   // first falling edge where all five resets show the row's levels
   task automatic wait_match(input int r);
      int   cycles;
      logic matched;
      cycles  = 0;
      matched = 1'b0;
      while (!matched) begin
         @(negedge pld_clk);
         cycles++;
         matched = (rst_levels === rows[r].expect_rst);
         if (!matched && cycles > row_timeout) begin
            $display("row %0d: resets did not reach %b within %0d cycles",
                     r, rows[r].expect_rst, row_timeout);
            end_with_failure();
         end
      end
   endtask

   // once reached, the levels must stay put with no glitch
   task automatic check_hold(input int r);
      for (int i = 0; i < hold_cycles; i++) begin
         @(negedge pld_clk);
         check_all_resets(rows[r].expect_rst);
      end
   endtask

   initial begin
      int cycles;
      lfsr_state      = 32'he87673be;
      sim_mode        = 1'b1;
      clk_125         = 1'b1;
      ltssm           = rs_serdes_pkg::ltssm_detect_quiet;
      dlup_exit       = 1'b1;
      hotrst_exit     = 1'b1;
      l2_exit         = 1'b1;
      pll_locked      = 1'b0;
      tx_cal_busy     = 1'b0;
      rx_cal_busy     = 1'b0;
      fifo_err        = 1'b0;
      rx_pll_locked   = '0;
      rx_freqlocked   = '0;
      rx_signaldetect = '0;
      load_table();

      // all resets high while arst is held and just after it drops
      @(negedge pld_clk);
      check_all_resets(5'b11111);
      cycles = 0;
      while (arst) begin
         @(posedge pld_clk);
         cycles++;
         if (cycles > reset_timeout) begin
            $display("arst was never released");
            end_with_failure();
         end
      end
      @(negedge pld_clk);
      check_all_resets(5'b11111);

      for (int r = 0; r < n_rows; r++) begin
         apply_row(r);
         wait_match(r);
         check_hold(r);
         check_lane_mask("sd_sync", rs_serdes_top_inst.status_if_inst.sd_sync,
                         rows[r].sigdet);
         check_ltssm_code("ltssm_qq", rs_serdes_top_inst.status_if_inst.ltssm_qq, ltssm);
      end

      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
rtl/rs_serdes_pkg.sv
rtl/rs_status_if.sv
rtl/rs_status_sync.sv
rtl/rs_serdes_seq.sv
rtl/rs_sigdet_mon.sv
rtl/rs_core_reset.sv
rtl/rs_serdes_top.sv
tb/tb_clk_gen.sv
tb/tb_rs_serdes.sv
